// File: sources.f
+incdir+include
rtl/subsys_pkg.sv
rtl/subsys_reset_sync.sv
rtl/subsys_ppi_split.sv
rtl/subsys_clint.sv
rtl/subsys_inspect_mux.sv
rtl/subsys_main.sv
verification/tb_subsys_main.sv

// File: Makefile
# Verilator flow for the small-core subsystem

VERILATOR ?= verilator
TB_TOP    ?= tb_subsys_main
RTL_TOP   ?= subsys_main
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_subsys_main.sv
/*
  Testbench for the small-core subsystem top
  Table-driven ICB accesses, a system-peripheral responder,
  timer, interrupt and inspect-mode pad checks
*/
`timescale 1ns/1ps
`include "subsys_params.svh"

module tb_subsys_main
  import subsys_pkg::*;
;

  localparam int        NUM_ENTRIES = 14;
  localparam icb_addr_t CLINT       = `SUBSYS_CLINT_BASE;

  logic        hfclk;
  logic        rst_n;
  logic        test_mode;
  logic        tm_stop;
  logic        rtc_toggle;
  logic        ppi_icb_cmd_valid;
  logic        ppi_icb_cmd_ready;
  icb_addr_t   ppi_icb_cmd_addr;
  logic        ppi_icb_cmd_read;
  icb_data_t   ppi_icb_cmd_wdata;
  icb_mask_t   ppi_icb_cmd_wmask;
  logic        ppi_icb_rsp_valid;
  logic        ppi_icb_rsp_ready;
  logic        ppi_icb_rsp_err;
  icb_data_t   ppi_icb_rsp_rdata;
  logic        sysper_icb_cmd_valid;
  logic        sysper_icb_cmd_ready;
  icb_addr_t   sysper_icb_cmd_addr;
  logic        sysper_icb_cmd_read;
  icb_data_t   sysper_icb_cmd_wdata;
  icb_mask_t   sysper_icb_cmd_wmask;
  logic        sysper_icb_rsp_valid;
  logic        sysper_icb_rsp_ready;
  logic        sysper_icb_rsp_err;
  icb_data_t   sysper_icb_rsp_rdata;
  logic        tmr_irq;
  logic        sft_irq;
  logic        inspect_mode;
  icb_addr_t   inspect_pc;
  logic        inspect_jtag_clk;
  logic        inspect_por_rst;
  logic        inspect_32k_clk;
  logic        inspect_16m_clk;
  logic        inspect_pll_clk;
  logic        inspect_pc_29b;
  logic [31:0] gpioa_oval_core;
  logic [31:0] gpioa_oe_core;
  logic [31:0] pad_gpioa_oval;
  logic [31:0] pad_gpioa_oe;

  int          errors;
  integer      seed;
  icb_addr_t   pend_q[$];

  // Stimulus table held as one queue per column
  string       t_name[$];
  icb_addr_t   t_addr[$];
  logic        t_read[$];
  icb_data_t   t_wdata[$];
  icb_mask_t   t_wmask[$];
  icb_data_t   t_rdata[$];
  logic        t_err[$];

  subsys_main DUT (.*);

  always #10 hfclk = ~hfclk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic add_entry(input string name, input icb_addr_t addr, input logic rd,
                           input icb_data_t wdata, input icb_mask_t wmask,
                           input icb_data_t rdata, input logic err);
    t_name.push_back(name);
    t_addr.push_back(addr);
    t_read.push_back(rd);
    t_wdata.push_back(wdata);
    t_wmask.push_back(wmask);
    t_rdata.push_back(rdata);
    t_err.push_back(err);
  endtask

  task automatic load_table();
    add_entry("cmp_lo_wr",      CLINT + 32'h4000, 1'b0, 32'h1122_3344, 4'hF, 32'h0, 1'b0);
    add_entry("cmp_lo_rd",      CLINT + 32'h4000, 1'b1, 32'h0, 4'h0, 32'h1122_3344, 1'b0);
    add_entry("cmp_lo_part_wr", CLINT + 32'h4000, 1'b0, 32'hAABB_CCDD, 4'h5, 32'h0, 1'b0);
    add_entry("cmp_lo_part_rd", CLINT + 32'h4000, 1'b1, 32'h0, 4'h0, 32'h11BB_33DD, 1'b0);
    add_entry("cmp_hi_part_wr", CLINT + 32'h4004, 1'b0, 32'hCAFE_0000, 4'hC, 32'h0, 1'b0);
    add_entry("cmp_hi_part_rd", CLINT + 32'h4004, 1'b1, 32'h0, 4'h0, 32'hCAFE_FFFF, 1'b0);
    add_entry("msip_wr_ones",   CLINT,            1'b0, 32'hFFFF_FFFF, 4'hF, 32'h0, 1'b0);
    add_entry("msip_rd_bit0",   CLINT,            1'b1, 32'h0, 4'h0, 32'h0000_0001, 1'b0);
    add_entry("msip_wr_zero",   CLINT,            1'b0, 32'h0, 4'hF, 32'h0, 1'b0);
    add_entry("unmapped_wr",    CLINT + 32'h0100, 1'b0, 32'hFFFF_FFFF, 4'hF, 32'h0, 1'b0);
    add_entry("unmapped_rd",    CLINT + 32'h0100, 1'b1, 32'h0, 4'h0, 32'h0, 1'b0);
    // Peripheral answers are address XOR A5A5_5A5A with error on bit 2
    add_entry("sysper_rd",      32'h1000_0010, 1'b1, 32'h0, 4'h0, 32'hB5A5_5A4A, 1'b0);
    add_entry("sysper_wr_err",  32'h1000_0014, 1'b0, 32'h1234_5678, 4'h3, 32'hB5A5_5A4E, 1'b1);
    add_entry("sysper_rd_err",  32'h2000_0004, 1'b1, 32'h0, 4'h0, 32'h85A5_5A5E, 1'b1);
  endtask

  task automatic issue_cmd(input icb_addr_t addr, input logic rd, input icb_data_t wdata,
                           input icb_mask_t wmask);
    @(posedge hfclk);
    ppi_icb_cmd_valid <= 1'b1;
    ppi_icb_cmd_addr  <= addr;
    ppi_icb_cmd_read  <= rd;
    ppi_icb_cmd_wdata <= wdata;
    ppi_icb_cmd_wmask <= wmask;
    @(negedge hfclk);
    while (!ppi_icb_cmd_ready) begin
      @(negedge hfclk);
    end
    @(posedge hfclk);
    ppi_icb_cmd_valid <= 1'b0;
  endtask

  // Latency counts falling edges from the accepting edge to rsp_valid
  task automatic collect_rsp(output icb_data_t rdata, output logic err, output int lat);
    lat = 0;
    ppi_icb_rsp_ready <= 1'b1;
    do begin
      @(negedge hfclk);
      lat++;
    end while (!ppi_icb_rsp_valid);
    rdata = ppi_icb_rsp_rdata;
    err   = ppi_icb_rsp_err;
    @(posedge hfclk);
    ppi_icb_rsp_ready <= 1'b0;
  endtask

  task automatic do_access(input icb_addr_t addr, input logic rd, input icb_data_t wdata,
                           input icb_mask_t wmask, output icb_data_t rdata);
    logic err;
    int   lat;
    issue_cmd(addr, rd, wdata, wmask);
    collect_rsp(rdata, err, lat);
  endtask

  task automatic pulse_rtc(input int n);
    repeat (n) begin
      @(posedge hfclk);
      rtc_toggle <= 1'b1;
      repeat (2) @(posedge hfclk);
      rtc_toggle <= 1'b0;
      repeat (2) @(posedge hfclk);
    end
    repeat (6) @(posedge hfclk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // System-peripheral responder

  always @(negedge hfclk) begin
    if (sysper_icb_cmd_valid && sysper_icb_cmd_ready) begin
      if (sysper_icb_cmd_addr[31:16] == CLINT[31:16]) begin
        errors++;
        $display("CLINT address %h was routed to the peripheral port", sysper_icb_cmd_addr);
      end
      compare_word("sysper_addr", ppi_icb_cmd_addr, sysper_icb_cmd_addr);
      compare_word("sysper_read", 32'(ppi_icb_cmd_read), 32'(sysper_icb_cmd_read));
      compare_word("sysper_wdata", ppi_icb_cmd_wdata, sysper_icb_cmd_wdata);
      compare_word("sysper_wmask", 32'(ppi_icb_cmd_wmask), 32'(sysper_icb_cmd_wmask));
      pend_q.push_back(sysper_icb_cmd_addr);
    end
  end

  always begin : sysper_reply
    icb_addr_t a;
    int        delay;
    @(posedge hfclk);
    if (pend_q.size() > 0) begin
      a     = pend_q.pop_front();
      delay = int'($unsigned($random(seed)) % 4);
      repeat (delay) @(posedge hfclk);
      sysper_icb_rsp_valid <= 1'b1;
      sysper_icb_rsp_rdata <= a ^ 32'hA5A5_5A5A;
      sysper_icb_rsp_err   <= a[2];
      @(negedge hfclk);
      while (!sysper_icb_rsp_ready) begin
        @(negedge hfclk);
      end
      @(posedge hfclk);
      sysper_icb_rsp_valid <= 1'b0;
    end
  end

  initial begin : watchdog
    repeat (NUM_ENTRIES * 50 + 2000) @(posedge hfclk);
    $display("Timeout, the run did not finish in time");
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin : main_seq
    icb_data_t   rdata;
    icb_data_t   rdata_b;
    icb_data_t   mt_lo;
    logic        err;
    logic        err_b;
    int          lat;
    logic [31:0] exp_pad;
    hfclk = 1'b0;
    rst_n = 1'b0;
    test_mode = 1'b0;
    tm_stop = 1'b0;
    rtc_toggle = 1'b0;
    ppi_icb_cmd_valid = 1'b0;
    ppi_icb_cmd_addr = '0;
    ppi_icb_cmd_read = 1'b0;
    ppi_icb_cmd_wdata = '0;
    ppi_icb_cmd_wmask = '0;
    ppi_icb_rsp_ready = 1'b0;
    sysper_icb_cmd_ready = 1'b1;
    sysper_icb_rsp_valid = 1'b0;
    sysper_icb_rsp_err = 1'b0;
    sysper_icb_rsp_rdata = '0;
    inspect_mode = 1'b0;
    inspect_pc = '0;
    inspect_jtag_clk = 1'b0;
    inspect_por_rst = 1'b0;
    inspect_32k_clk = 1'b0;
    inspect_16m_clk = 1'b0;
    inspect_pll_clk = 1'b0;
    gpioa_oval_core = '0;
    gpioa_oe_core = '0;
    errors = 0;
    seed = 65122;
    load_table();

    repeat (5) @(posedge hfclk);
    rst_n <= 1'b1;
    repeat (5) @(posedge hfclk);
    @(negedge hfclk);
    compare_word("reset_rsp_valid", 32'd0, 32'(ppi_icb_rsp_valid));
    compare_word("reset_sysper_valid", 32'd0, 32'(sysper_icb_cmd_valid));
    compare_word("reset_tmr_irq", 32'd0, 32'(tmr_irq));
    compare_word("reset_sft_irq", 32'd0, 32'(sft_irq));

    // Table of single accesses
    for (int i = 0; i < t_name.size(); i++) begin
      issue_cmd(t_addr[i], t_read[i], t_wdata[i], t_wmask[i]);
      collect_rsp(rdata, err, lat);
      if (t_read[i] || t_addr[i][31:16] != CLINT[31:16]) begin
        compare_word(t_name[i], t_rdata[i], rdata);
      end
      compare_word({t_name[i], "_err"}, 32'(t_err[i]), 32'(err));
      if (t_addr[i][31:16] == CLINT[31:16]) begin
        compare_word({t_name[i], "_latency"}, 32'd1, 32'(lat));
      end
    end

    // Time base counting and freeze under tm_stop
    pulse_rtc(5);
    do_access(CLINT + 32'hBFF8, 1'b1, '0, '0, rdata);
    compare_word("mtime_after_ticks", 32'd5, rdata);
    tm_stop <= 1'b1;
    pulse_rtc(4);
    do_access(CLINT + 32'hBFF8, 1'b1, '0, '0, rdata);
    compare_word("mtime_stopped", 32'd5, rdata);
    tm_stop <= 1'b0;

    // Software and timer interrupts
    do_access(CLINT, 1'b0, 32'h1, 4'hF, rdata);
    @(negedge hfclk);
    compare_word("sft_irq_set", 32'd1, 32'(sft_irq));
    do_access(CLINT, 1'b0, 32'h0, 4'hF, rdata);
    @(negedge hfclk);
    compare_word("sft_irq_clear", 32'd0, 32'(sft_irq));
    do_access(CLINT + 32'hBFF8, 1'b1, '0, '0, mt_lo);
    do_access(CLINT + 32'h4004, 1'b0, 32'h0, 4'hF, rdata);
    do_access(CLINT + 32'h4000, 1'b0, mt_lo, 4'hF, rdata);
    @(negedge hfclk);
    compare_word("tmr_irq_set", 32'd1, 32'(tmr_irq));
    do_access(CLINT + 32'h4000, 1'b0, mt_lo + 32'd100, 4'hF, rdata);
    @(negedge hfclk);
    compare_word("tmr_irq_clear", 32'd0, 32'(tmr_irq));

    // Two outstanding with responses held back and then a mixed pair
    issue_cmd(32'h1000_0020, 1'b1, '0, '0);
    issue_cmd(32'h1000_0024, 1'b1, '0, '0);
    repeat (6) @(posedge hfclk);
    @(negedge hfclk);
    compare_word("queue_full_cmd_ready", 32'd0, 32'(ppi_icb_cmd_ready));
    @(posedge hfclk);
    collect_rsp(rdata, err, lat);
    collect_rsp(rdata_b, err_b, lat);
    compare_word("outstanding_first", 32'hB5A5_5A7A, rdata);
    compare_word("outstanding_first_err", 32'd0, 32'(err));
    compare_word("outstanding_second", 32'hB5A5_5A7E, rdata_b);
    compare_word("outstanding_second_err", 32'd1, 32'(err_b));
    issue_cmd(32'h1000_0030, 1'b1, '0, '0);
    issue_cmd(CLINT + 32'h4004, 1'b1, '0, '0);
    collect_rsp(rdata, err, lat);
    collect_rsp(rdata_b, err_b, lat);
    compare_word("mixed_sysper_first", 32'hB5A5_5A6A, rdata);
    compare_word("mixed_clint_second", 32'h0, rdata_b);

    // Inspect-mode pad mux
    @(posedge hfclk);
    inspect_mode     <= 1'b1;
    inspect_pc       <= 32'h2ABC_DEF1;
    inspect_jtag_clk <= 1'b1;
    inspect_por_rst  <= 1'b0;
    inspect_32k_clk  <= 1'b1;
    inspect_16m_clk  <= 1'b0;
    inspect_pll_clk  <= 1'b1;
    gpioa_oval_core  <= 32'h5A5A_1234;
    gpioa_oe_core    <= 32'h0F0F_00FF;
    @(negedge hfclk);
    exp_pad        = '0;
    exp_pad[21:0]  = inspect_pc[21:0];
    exp_pad[22]    = ppi_icb_cmd_valid;
    // Queue empty and CLINT idle
    exp_pad[23]    = 1'b1;
    exp_pad[24]    = 1'b0;
    exp_pad[25]    = ppi_icb_rsp_ready;
    exp_pad[26]    = 1'b1;
    exp_pad[27]    = 1'b0;
    exp_pad[28]    = 1'b0;
    exp_pad[29]    = 1'b1;
    exp_pad[30]    = 1'b0;
    exp_pad[31]    = 1'b1;
    compare_word("inspect_oe", 32'hFFFF_FFFF, pad_gpioa_oe);
    compare_word("inspect_oval", exp_pad, pad_gpioa_oval);
    compare_word("inspect_pc_29b", 32'd1, 32'(inspect_pc_29b));
    @(posedge hfclk);
    inspect_mode <= 1'b0;
    @(negedge hfclk);
    compare_word("core_oe", 32'h0F0F_00FF, pad_gpioa_oe);
    compare_word("core_oval", 32'h5A5A_1234, pad_gpioa_oval);

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: rtl/subsys_main.sv
/*
  Small-core subsystem top
  Main reset sync, PPI splitter, CLINT and inspect-mode pad mux
*/
`timescale 1ns/1ps
`include "subsys_params.svh"

module subsys_main
  import subsys_pkg::*;
(
  input  logic        hfclk,
  input  logic        rst_n,
  input  logic        test_mode,
  input  logic        tm_stop,
  input  logic        rtc_toggle,
  // Core-side PPI target port
  input  logic        ppi_icb_cmd_valid,
  output logic        ppi_icb_cmd_ready,
  input  icb_addr_t   ppi_icb_cmd_addr,
  input  logic        ppi_icb_cmd_read,
  input  icb_data_t   ppi_icb_cmd_wdata,
  input  icb_mask_t   ppi_icb_cmd_wmask,
  output logic        ppi_icb_rsp_valid,
  input  logic        ppi_icb_rsp_ready,
  output logic        ppi_icb_rsp_err,
  output icb_data_t   ppi_icb_rsp_rdata,
  // System-peripheral initiator port
  output logic        sysper_icb_cmd_valid,
  input  logic        sysper_icb_cmd_ready,
  output icb_addr_t   sysper_icb_cmd_addr,
  output logic        sysper_icb_cmd_read,
  output icb_data_t   sysper_icb_cmd_wdata,
  output icb_mask_t   sysper_icb_cmd_wmask,
  input  logic        sysper_icb_rsp_valid,
  output logic        sysper_icb_rsp_ready,
  input  logic        sysper_icb_rsp_err,
  input  icb_data_t   sysper_icb_rsp_rdata,
  // Interrupts
  output logic        tmr_irq,
  output logic        sft_irq,
  // Inspect mode
  input  logic        inspect_mode,
  input  icb_addr_t   inspect_pc,
  input  logic        inspect_jtag_clk,
  input  logic        inspect_por_rst,
  input  logic        inspect_32k_clk,
  input  logic        inspect_16m_clk,
  input  logic        inspect_pll_clk,
  output logic        inspect_pc_29b,
  // GPIO-A
  input  logic [31:0] gpioa_oval_core,
  input  logic [31:0] gpioa_oe_core,
  output logic [31:0] pad_gpioa_oval,
  output logic [31:0] pad_gpioa_oe
);

  logic      main_rst_n;
  logic      clint_icb_cmd_valid;
  logic      clint_icb_cmd_ready;
  icb_addr_t clint_icb_cmd_addr;
  logic      clint_icb_cmd_read;
  icb_data_t clint_icb_cmd_wdata;
  icb_mask_t clint_icb_cmd_wmask;
  logic      clint_icb_rsp_valid;
  logic      clint_icb_rsp_ready;
  icb_data_t clint_icb_rsp_rdata;

  assign inspect_pc_29b = inspect_pc[29];

  subsys_reset_sync u_main_reset_sync (
    .hfclk      (hfclk),
    .rst_n      (rst_n),
    .test_mode  (test_mode),
    .main_rst_n (main_rst_n)
  );

  subsys_ppi_split #(
    .DEPTH (`SUBSYS_SPLIT_DEPTH)
  ) u_ppi_split (
    .hfclk            (hfclk),
    .rst_n            (main_rst_n),
    .ppi_cmd_valid    (ppi_icb_cmd_valid),
    .ppi_cmd_ready    (ppi_icb_cmd_ready),
    .ppi_cmd_addr     (ppi_icb_cmd_addr),
    .ppi_cmd_read     (ppi_icb_cmd_read),
    .ppi_cmd_wdata    (ppi_icb_cmd_wdata),
    .ppi_cmd_wmask    (ppi_icb_cmd_wmask),
    .ppi_rsp_valid    (ppi_icb_rsp_valid),
    .ppi_rsp_ready    (ppi_icb_rsp_ready),
    .ppi_rsp_err      (ppi_icb_rsp_err),
    .ppi_rsp_rdata    (ppi_icb_rsp_rdata),
    .clint_cmd_valid  (clint_icb_cmd_valid),
    .clint_cmd_ready  (clint_icb_cmd_ready),
    .clint_cmd_addr   (clint_icb_cmd_addr),
    .clint_cmd_read   (clint_icb_cmd_read),
    .clint_cmd_wdata  (clint_icb_cmd_wdata),
    .clint_cmd_wmask  (clint_icb_cmd_wmask),
    .clint_rsp_valid  (clint_icb_rsp_valid),
    .clint_rsp_ready  (clint_icb_rsp_ready),
    .clint_rsp_rdata  (clint_icb_rsp_rdata),
    .sysper_cmd_valid (sysper_icb_cmd_valid),
    .sysper_cmd_ready (sysper_icb_cmd_ready),
    .sysper_cmd_addr  (sysper_icb_cmd_addr),
    .sysper_cmd_read  (sysper_icb_cmd_read),
    .sysper_cmd_wdata (sysper_icb_cmd_wdata),
    .sysper_cmd_wmask (sysper_icb_cmd_wmask),
    .sysper_rsp_valid (sysper_icb_rsp_valid),
    .sysper_rsp_ready (sysper_icb_rsp_ready),
    .sysper_rsp_err   (sysper_icb_rsp_err),
    .sysper_rsp_rdata (sysper_icb_rsp_rdata)
  );

  subsys_clint u_clint (
    .hfclk           (hfclk),
    .rst_n           (main_rst_n),
    .tm_stop         (tm_stop),
    .rtc_toggle      (rtc_toggle),
    .clint_cmd_valid (clint_icb_cmd_valid),
    .clint_cmd_ready (clint_icb_cmd_ready),
    .clint_cmd_addr  (clint_icb_cmd_addr),
    .clint_cmd_read  (clint_icb_cmd_read),
    .clint_cmd_wdata (clint_icb_cmd_wdata),
    .clint_cmd_wmask (clint_icb_cmd_wmask),
    .clint_rsp_valid (clint_icb_rsp_valid),
    .clint_rsp_ready (clint_icb_rsp_ready),
    .clint_rsp_rdata (clint_icb_rsp_rdata),
    .tmr_irq         (tmr_irq),
    .sft_irq         (sft_irq)
  );

  // Observe the core-side PPI handshake
  subsys_inspect_mux u_inspect_mux (
    .inspect_mode    (inspect_mode),
    .inspect_pc      (inspect_pc),
    .obs_cmd_valid   (ppi_icb_cmd_valid),
    .obs_cmd_ready   (ppi_icb_cmd_ready),
    .obs_rsp_valid   (ppi_icb_rsp_valid),
    .obs_rsp_ready   (ppi_icb_rsp_ready),
    .hfclk           (hfclk),
    .jtag_clk        (inspect_jtag_clk),
    .por_rst         (inspect_por_rst),
    .clk_32k         (inspect_32k_clk),
    .clk_16m         (inspect_16m_clk),
    .pll_clk         (inspect_pll_clk),
    .gpioa_oval_core (gpioa_oval_core),
    .gpioa_oe_core   (gpioa_oe_core),
    .pad_gpioa_oval  (pad_gpioa_oval),
    .pad_gpioa_oe    (pad_gpioa_oe)
  );

endmodule

// File: rtl/subsys_inspect_mux.sv
/*
  Inspect-mode GPIO-A pad mux
  Drives PC, bus handshake and clock observation onto the pads
  in inspect mode, core values otherwise
*/
`timescale 1ns/1ps
`include "subsys_params.svh"

module subsys_inspect_mux
  import subsys_pkg::*;
(
  input  logic        inspect_mode,
  input  icb_addr_t   inspect_pc,
  input  logic        obs_cmd_valid,
  input  logic        obs_cmd_ready,
  input  logic        obs_rsp_valid,
  input  logic        obs_rsp_ready,
  input  logic        hfclk,
  input  logic        jtag_clk,
  input  logic        por_rst,
  input  logic        clk_32k,
  input  logic        clk_16m,
  input  logic        pll_clk,
  input  logic [31:0] gpioa_oval_core,
  input  logic [31:0] gpioa_oe_core,
  output logic [31:0] pad_gpioa_oval,
  output logic [31:0] pad_gpioa_oe
);

  logic [31:0] obs_val;

  // Clocks on the top six pads, handshakes above the PC bits
  assign obs_val = {pll_clk, clk_16m, clk_32k, por_rst, hfclk, jtag_clk,
                    obs_rsp_ready, obs_rsp_valid, obs_cmd_ready, obs_cmd_valid,
                    inspect_pc[`SUBSYS_PC_OBS_W-1:0]};

  // All pads become outputs while inspecting
  assign pad_gpioa_oe   = inspect_mode ? '1 : gpioa_oe_core;
  assign pad_gpioa_oval = inspect_mode ? obs_val : gpioa_oval_core;

endmodule

// File: rtl/subsys_clint.sv
/*
  Core-local interruptor
  Holds msip, mtime and mtimecmp behind an ICB target port,
  counts RTC toggle edges and raises software and timer interrupts
*/
`timescale 1ns/1ps
`include "subsys_params.svh"

module subsys_clint
  import subsys_pkg::*;
(
  input  logic      hfclk,
  input  logic      rst_n,
  input  logic      tm_stop,
  input  logic      rtc_toggle,
  // ICB target port
  input  logic      clint_cmd_valid,
  output logic      clint_cmd_ready,
  input  icb_addr_t clint_cmd_addr,
  input  logic      clint_cmd_read,
  input  icb_data_t clint_cmd_wdata,
  input  icb_mask_t clint_cmd_wmask,
  output logic      clint_rsp_valid,
  input  logic      clint_rsp_ready,
  output icb_data_t clint_rsp_rdata,
  // Interrupts to the core
  output logic      tmr_irq,
  output logic      sft_irq
);

  localparam int SPAN_W = `SUBSYS_CLINT_SPAN_W;

  logic [SPAN_W-1:0] cmd_off;
  logic              cmd_hsk;
  logic              wr_en;
  logic              rsp_valid_q;
  icb_data_t         rsp_rdata_q;
  icb_data_t         rd_data;
  mtime_t            mtime;
  mtime_t            mtimecmp;
  logic              msip;
  logic [1:0]        rtc_sync;
  logic              rtc_prev;
  logic              rtc_tick;

  // Replace the enabled byte lanes of a word
  function automatic icb_data_t byte_merge(icb_data_t old_val, icb_data_t new_val,
                                           icb_mask_t mask);
    icb_data_t res;
    res = old_val;
    for (int i = 0; i < `SUBSYS_MASK_W; i++) begin
      if (mask[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus handshake, one response in flight

  assign cmd_off         = clint_cmd_addr[SPAN_W-1:0];
  assign clint_cmd_ready = ~rsp_valid_q | clint_rsp_ready;
  assign cmd_hsk         = clint_cmd_valid & clint_cmd_ready;
  assign wr_en           = cmd_hsk & ~clint_cmd_read;

  always_ff @(posedge hfclk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else if (cmd_hsk) begin
      rsp_valid_q <= 1'b1;
    end else if (clint_rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge hfclk) begin
    if (cmd_hsk) begin
      rsp_rdata_q <= clint_cmd_read ? rd_data : '0;
    end
  end

  assign clint_rsp_valid = rsp_valid_q;
  assign clint_rsp_rdata = rsp_rdata_q;

  // Read mux, unmapped offsets give zero
  always_comb begin
    case (cmd_off)
      `SUBSYS_CLINT_MSIP:        rd_data = icb_data_t'(msip);
      `SUBSYS_CLINT_MTIMECMP_LO: rd_data = mtimecmp[0];
      `SUBSYS_CLINT_MTIMECMP_HI: rd_data = mtimecmp[1];
      `SUBSYS_CLINT_MTIME_LO:    rd_data = mtime[0];
      `SUBSYS_CLINT_MTIME_HI:    rd_data = mtime[1];
      default:                   rd_data = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers

  always_ff @(posedge hfclk or negedge rst_n) begin
    if (!rst_n) begin
      msip <= 1'b0;
    end else if (wr_en && cmd_off == `SUBSYS_CLINT_MSIP && clint_cmd_wmask[0]) begin
      msip <= clint_cmd_wdata[0];
    end
  end

  // Compare value starts at all ones so no timer interrupt out of reset
  always_ff @(posedge hfclk or negedge rst_n) begin
    if (!rst_n) begin
      mtimecmp <= '1;
    end else if (wr_en && cmd_off == `SUBSYS_CLINT_MTIMECMP_LO) begin
      mtimecmp[0] <= byte_merge(mtimecmp[0], clint_cmd_wdata, clint_cmd_wmask);
    end else if (wr_en && cmd_off == `SUBSYS_CLINT_MTIMECMP_HI) begin
      mtimecmp[1] <= byte_merge(mtimecmp[1], clint_cmd_wdata, clint_cmd_wmask);
    end
  end

  // RTC toggle crosses in through two flops, third flop finds the edge
  always_ff @(posedge hfclk or negedge rst_n) begin
    if (!rst_n) begin
      rtc_sync <= 2'b00;
      rtc_prev <= 1'b0;
    end else begin
      rtc_sync <= {rtc_sync[0], rtc_toggle};
      rtc_prev <= rtc_sync[1];
    end
  end

  assign rtc_tick = rtc_sync[1] & ~rtc_prev;

  // Bus write takes priority over a tick in the same cycle
  always_ff @(posedge hfclk or negedge rst_n) begin
    if (!rst_n) begin
      mtime <= '0;
    end else if (wr_en && cmd_off == `SUBSYS_CLINT_MTIME_LO) begin
      mtime[0] <= byte_merge(mtime[0], clint_cmd_wdata, clint_cmd_wmask);
    end else if (wr_en && cmd_off == `SUBSYS_CLINT_MTIME_HI) begin
      mtime[1] <= byte_merge(mtime[1], clint_cmd_wdata, clint_cmd_wmask);
    end else if (rtc_tick && !tm_stop) begin
      mtime <= mtime + 64'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Interrupts

  assign tmr_irq = (mtime >= mtimecmp);
  assign sft_irq = msip;

endmodule

// File: rtl/subsys_ppi_split.sv
/*
  Private-peripheral ICB splitter
  Routes each command to the CLINT or to the system-peripheral port
  by address, and returns responses in command order using a small
  queue of outstanding destinations
*/
`timescale 1ns/1ps
`include "subsys_params.svh"

module subsys_ppi_split
  import subsys_pkg::*;
#(
  parameter int DEPTH = `SUBSYS_SPLIT_DEPTH
) (
  input  logic      hfclk,
  input  logic      rst_n,
  // Upstream target port
  input  logic      ppi_cmd_valid,
  output logic      ppi_cmd_ready,
  input  icb_addr_t ppi_cmd_addr,
  input  logic      ppi_cmd_read,
  input  icb_data_t ppi_cmd_wdata,
  input  icb_mask_t ppi_cmd_wmask,
  output logic      ppi_rsp_valid,
  input  logic      ppi_rsp_ready,
  output logic      ppi_rsp_err,
  output icb_data_t ppi_rsp_rdata,
  // CLINT initiator port
  output logic      clint_cmd_valid,
  input  logic      clint_cmd_ready,
  output icb_addr_t clint_cmd_addr,
  output logic      clint_cmd_read,
  output icb_data_t clint_cmd_wdata,
  output icb_mask_t clint_cmd_wmask,
  input  logic      clint_rsp_valid,
  output logic      clint_rsp_ready,
  input  icb_data_t clint_rsp_rdata,
  // System-peripheral initiator port
  output logic      sysper_cmd_valid,
  input  logic      sysper_cmd_ready,
  output icb_addr_t sysper_cmd_addr,
  output logic      sysper_cmd_read,
  output icb_data_t sysper_cmd_wdata,
  output icb_mask_t sysper_cmd_wmask,
  input  logic      sysper_rsp_valid,
  output logic      sysper_rsp_ready,
  input  logic      sysper_rsp_err,
  input  icb_data_t sysper_rsp_rdata
);

  localparam int        ADDR_W     = `SUBSYS_ADDR_W;
  localparam int        SPAN_W     = `SUBSYS_CLINT_SPAN_W;
  localparam icb_addr_t CLINT_BASE = `SUBSYS_CLINT_BASE;
  localparam int        PTR_W      = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int        CNT_W      = $clog2(DEPTH + 1);

  ppi_dest_e        cmd_dest;
  ppi_dest_e        head_dest;
  ppi_dest_e        dest_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             q_full;
  logic             q_empty;
  logic             tgt_ready;
  logic             push;
  logic             pop;

  ////////////////////////////////////////////////////////////////////////////
  // Command path

  assign cmd_dest = (ppi_cmd_addr[ADDR_W-1:SPAN_W] == CLINT_BASE[ADDR_W-1:SPAN_W]) ?
                    DEST_CLINT : DEST_SYSPER;

  assign q_full    = (count == CNT_W'(DEPTH));
  assign q_empty   = (count == '0);
  assign tgt_ready = (cmd_dest == DEST_CLINT) ? clint_cmd_ready : sysper_cmd_ready;

  assign ppi_cmd_ready    = tgt_ready & ~q_full;
  assign clint_cmd_valid  = ppi_cmd_valid & ~q_full & (cmd_dest == DEST_CLINT);
  assign sysper_cmd_valid = ppi_cmd_valid & ~q_full & (cmd_dest == DEST_SYSPER);

  // Payload fans out to both targets
  assign clint_cmd_addr   = ppi_cmd_addr;
  assign clint_cmd_read   = ppi_cmd_read;
  assign clint_cmd_wdata  = ppi_cmd_wdata;
  assign clint_cmd_wmask  = ppi_cmd_wmask;
  assign sysper_cmd_addr  = ppi_cmd_addr;
  assign sysper_cmd_read  = ppi_cmd_read;
  assign sysper_cmd_wdata = ppi_cmd_wdata;
  assign sysper_cmd_wmask = ppi_cmd_wmask;

  ////////////////////////////////////////////////////////////////////////////
  // Response path, only the oldest target may answer

  assign head_dest = dest_q[rd_ptr];

  assign ppi_rsp_valid    = ~q_empty & ((head_dest == DEST_CLINT) ?
                                        clint_rsp_valid : sysper_rsp_valid);
  assign ppi_rsp_err      = (head_dest == DEST_CLINT) ? 1'b0 : sysper_rsp_err;
  assign ppi_rsp_rdata    = (head_dest == DEST_CLINT) ? clint_rsp_rdata : sysper_rsp_rdata;
  assign clint_rsp_ready  = ~q_empty & (head_dest == DEST_CLINT) & ppi_rsp_ready;
  assign sysper_rsp_ready = ~q_empty & (head_dest == DEST_SYSPER) & ppi_rsp_ready;

  assign push = ppi_cmd_valid & ppi_cmd_ready;
  assign pop  = ppi_rsp_valid & ppi_rsp_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Destination queue

  always_ff @(posedge hfclk) begin
    if (push) begin
      dest_q[wr_ptr] <= cmd_dest;
    end
  end

  always_ff @(posedge hfclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rtl/subsys_reset_sync.sv
/*
  Main-domain reset catch-and-sync
  Asserts at once, releases on the third clock edge,
  bypassed in test mode
*/
`timescale 1ns/1ps

module subsys_reset_sync (
  input  logic hfclk,
  input  logic rst_n,
  input  logic test_mode,
  output logic main_rst_n
);

  logic [2:0] sync_q;

  // Clear on raw reset, shift ones in after release
  always_ff @(posedge hfclk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 3'b000;
    end else begin
      sync_q <= {sync_q[1:0], 1'b1};
    end
  end

  // Scan needs direct control of the reset
  assign main_rst_n = test_mode ? rst_n : sync_q[2];

endmodule

// File: rtl/subsys_pkg.sv
/*
  Small-core subsystem shared types
  ICB payload words, PPI target select and the 64-bit timer value
*/
`include "subsys_params.svh"

package subsys_pkg;

  // ICB command and response payload
  typedef logic [`SUBSYS_ADDR_W-1:0] icb_addr_t;
  typedef logic [`SUBSYS_XLEN-1:0]   icb_data_t;
  typedef logic [`SUBSYS_MASK_W-1:0] icb_mask_t;

  // Target of a private-peripheral access
  typedef enum logic {
    DEST_CLINT  = 1'b0,
    DEST_SYSPER = 1'b1
  } ppi_dest_e;

  // Timer value, word 0 is the low half
  typedef logic [1:0][`SUBSYS_XLEN-1:0] mtime_t;

endpackage

// File: include/subsys_params.svh
/*
  Small-core subsystem parameters
  Bus widths, CLINT address map and inspect-mode pad layout
*/
`ifndef SUBSYS_PARAMS_SVH
`define SUBSYS_PARAMS_SVH

// ICB bus widths
`define SUBSYS_ADDR_W            32
`define SUBSYS_XLEN              32
`define SUBSYS_MASK_W            (`SUBSYS_XLEN/8)

// CLINT window, selected by the bits above the span
`define SUBSYS_CLINT_BASE        32'h0200_0000
`define SUBSYS_CLINT_SPAN_W      16

// CLINT register offsets inside the window
`define SUBSYS_CLINT_MSIP        16'h0000
`define SUBSYS_CLINT_MTIMECMP_LO 16'h4000
`define SUBSYS_CLINT_MTIMECMP_HI 16'h4004
`define SUBSYS_CLINT_MTIME_LO    16'hBFF8
`define SUBSYS_CLINT_MTIME_HI    16'hBFFC

// Outstanding commands through the PPI splitter
`define SUBSYS_SPLIT_DEPTH       2

// PC bits driven onto GPIO-A in inspect mode
`define SUBSYS_PC_OBS_W          22

`endif
